// File: cp0Regs.f
hw/cp0Pkg.sv
hw/excPkg.sv
hw/cp0WriteDecode.sv
hw/cp0Timer.sv
hw/cp0ExcRegs.sv
hw/cp0ReadMux.sv
hw/cp0Top.sv
tests/cp0Top_chk.sv
tests/cp0Tb.sv

// File: hw/cp0ExcRegs.sv
// Status, Cause, EPC, BadVAddr, EBase and Config0 state with the interrupt summary
`default_nettype none

module cp0ExcRegs
    import cp0Pkg::*;
    import excPkg::*;
#(
    parameter logic [31:0] ebaseReset   = 32'h80000000,
    parameter logic [31:0] config0Reset = 32'h80000483
) (
    input  logic        clk,
    input  logic        reset,
    input  regStrobes   strobes,
    input  excAction    act,
    input  logic [31:0] wrData,
    input  logic [5:0]  hwInt,
    input  logic        ti,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    output cp0State     state,
    output cp0View      view
);

    logic bev;
    logic [7:0] im;
    logic exl;
    logic ie;
    logic bd;
    logic [1:0] ce;
    logic [7:0] ip;
    logic [4:0] excCode;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic [ebaseMsb:ebaseLsb] ebaseField;
    logic [k0Width-1:0] k0;
    logic capture;

    // First-level exception only, nested ones keep EPC and BD
    assign capture = act.take && !act.isEret && !exl;

    always_ff @(posedge clk) begin
        if (reset) begin
            bev <= 1'b1;
            im  <= '0;
            ie  <= 1'b0;
            exl <= 1'b0;
        end else begin
            if (strobes.status) begin
                bev <= wrData[bevBit];
                im  <= wrData[imLsb +: 8];
                ie  <= wrData[ieBit];
            end
            if (act.take) begin
                exl <= !act.isEret;     // Exception beats a Status move
            end else if (strobes.status) begin
                exl <= wrData[exlBit];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bd      <= 1'b0;
            ce      <= '0;
            ip      <= '0;
            excCode <= '0;
        end else begin
            ip[7:2] <= {hwInt[5] | ti, hwInt[4:0]};
            if (strobes.cause) ip[1:0] <= wrData[ipLsb +: 2]; // Software interrupts
            if (capture) bd <= act.inDelaySlot;
            if (act.codeValid) excCode <= act.code;
            if (act.setCe) ce <= 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (act.take) begin
            if (capture) epc <= act.epcValue;
        end else if (strobes.epc) begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badVAddr   <= '0;
            ebaseField <= ebaseReset[ebaseMsb:ebaseLsb];
            k0         <= config0Reset[k0Width-1:0];
        end else begin
            if (act.badValid) badVAddr <= act.badAddr;
            if (strobes.ebase) ebaseField <= wrData[ebaseMsb:ebaseLsb];
            if (strobes.config0) k0 <= wrData[k0Width-1:0];
        end
    end

    always_comb begin
        state          = '0;
        state.bev      = bev;
        state.im       = im;
        state.exl      = exl;
        state.ie       = ie;
        state.bd       = bd;
        state.ti       = ti;
        state.ce       = ce;
        state.ip       = ip;
        state.excCode  = excCode;
        state.epc      = epc;
        state.badVAddr = badVAddr;
        state.ebase    = {ebaseReset[31:ebaseMsb+1], ebaseField, ebaseReset[ebaseLsb-1:0]};
        state.cfgUpper = config0Reset[31:k0Width];
        state.k0       = k0;
        state.count    = count;
        state.compare  = compare;
    end

    always_comb begin
        view            = '0;
        view.bev        = bev;
        view.im         = im;
        view.exl        = exl;
        view.ie         = ie;
        view.ip         = ip;
        view.epc        = epc;
        view.ebase      = state.ebase;
        view.k0         = k0;
        view.irqPending = ie && !exl && |(ip & im);
    end

endmodule

`default_nettype wire

// File: hw/cp0Pkg.sv
// CP0 register numbers, field positions and the register-side structs
`default_nettype none

package cp0Pkg;

    typedef enum logic [4:0] {
        regBadVAddr = 5'd8,
        regCount    = 5'd9,
        regCompare  = 5'd11,
        regStatus   = 5'd12,
        regCause    = 5'd13,
        regEpc      = 5'd14,
        regPrid     = 5'd15,    // sel 1 is EBase
        regConfig   = 5'd16
    } cp0RegAddr;

    // Status bit positions
    localparam int bevBit = 22;
    localparam int imLsb  = 8;
    localparam int exlBit = 1;
    localparam int ieBit  = 0;

    // Cause bit positions
    localparam int bdBit      = 31;
    localparam int tiBit      = 30;
    localparam int ceLsb      = 28;
    localparam int ipLsb      = 8;
    localparam int excCodeLsb = 2;

    localparam int ebaseLsb = 12;   // EBase[29:12] writable
    localparam int ebaseMsb = 29;
    localparam int k0Width  = 3;

    typedef struct packed {
        logic      wrEn;
        cp0RegAddr addr;
        logic [2:0]  sel;
        logic [31:0] data;
    } cp0WriteReq;

    typedef struct packed {
        logic status;
        logic cause;
        logic epc;
        logic compare;
        logic count;
        logic ebase;
        logic config0;
    } regStrobes;

    typedef struct packed {
        logic bev;
        logic [7:0] im;
        logic exl;
        logic ie;
        logic bd;
        logic ti;
        logic [1:0] ce;
        logic [7:0] ip;
        logic [4:0] excCode;
        logic [31:0] epc;
        logic [31:0] badVAddr;
        logic [31:0] ebase;
        logic [31-k0Width:0] cfgUpper;  // Fixed Config0 bits above K0
        logic [k0Width-1:0] k0;
        logic [31:0] count;
        logic [31:0] compare;
    } cp0State;

    // Fields the exception logic watches
    typedef struct packed {
        logic bev;
        logic [7:0] im;
        logic exl;
        logic ie;
        logic [7:0] ip;
        logic [31:0] epc;
        logic [31:0] ebase;
        logic [k0Width-1:0] k0;
        logic irqPending;
    } cp0View;

endpackage

`default_nettype wire

// File: hw/cp0ReadMux.sv
// CP0 read port with Status and Cause word packing
`default_nettype none

module cp0ReadMux
    import cp0Pkg::*;
#(
    parameter logic [31:0] pridValue = 32'h00004220
) (
    input  cp0RegAddr   rdAddr,
    input  logic [2:0]  rdSel,
    input  cp0State     state,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    output logic [31:0] rdData
);

    logic [31:0] statusWord;
    logic [31:0] causeWord;

    always_comb begin
        statusWord               = '0;
        statusWord[bevBit]       = state.bev;
        statusWord[imLsb +: 8]   = state.im;
        statusWord[exlBit]       = state.exl;
        statusWord[ieBit]        = state.ie;
    end

    always_comb begin
        causeWord                    = '0;
        causeWord[bdBit]             = state.bd;
        causeWord[tiBit]             = state.ti;
        causeWord[ceLsb +: 2]        = state.ce;
        causeWord[ipLsb +: 8]        = state.ip;
        causeWord[excCodeLsb +: 5]   = state.excCode;
    end

    always_comb begin
        rdData = '0;    // Unimplemented registers
        case (rdAddr)
            regBadVAddr: rdData = state.badVAddr;
            regCount:    rdData = count;
            regCompare:  rdData = compare;
            regStatus:   rdData = statusWord;
            regCause:    rdData = causeWord;
            regEpc:      rdData = state.epc;
            regPrid: begin
                if (rdSel == 3'd0) rdData = pridValue;
                else if (rdSel == 3'd1) rdData = state.ebase;
            end
            regConfig: begin
                if (rdSel == 3'd0) rdData = {state.cfgUpper, state.k0};
            end
            default: rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cp0Timer.sv
// Count with its prescaler, Compare and the sticky timer interrupt flag
`default_nettype none

module cp0Timer
    import cp0Pkg::*;
#(
    parameter int countDivBits = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  regStrobes   strobes,
    input  logic [31:0] wrData,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        ti
);

    logic [countDivBits-1:0] divCnt;
    logic tick;

    assign tick = &divCnt;  // Last cycle of the divide period

    always_ff @(posedge clk) begin
        if (reset) begin
            divCnt <= '0;
            count  <= '0;
        end else if (strobes.count) begin
            divCnt <= '0;
            count  <= wrData;
        end else begin
            divCnt <= divCnt + 1'b1;
            if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '0;
        end else if (strobes.compare) begin
            compare <= wrData;
        end
    end

    // Stays set until software rewrites Compare
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (strobes.compare) begin
            ti <= 1'b0;
        end else if (count == compare) begin
            ti <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/cp0Top.sv
// CP0 register block top: write decode, timer, exception state and read port
`default_nettype none

module cp0Top
    import cp0Pkg::*;
    import excPkg::*;
#(
    parameter logic [31:0] pridValue    = 32'h00004220,
    parameter logic [31:0] ebaseReset   = 32'h80000000,
    parameter logic [31:0] config0Reset = 32'h80000483,
    parameter int          countDivBits = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  hwInt,
    input  cp0WriteReq  wrReq,
    input  excEvent     exc,
    input  cp0RegAddr   rdAddr,
    input  logic [2:0]  rdSel,
    output logic [31:0] rdData,
    output cp0View      view
);

    regStrobes strobes;
    excAction act;
    logic [31:0] count;
    logic [31:0] compare;
    logic ti;
    cp0State state;

    cp0WriteDecode decodeInst (
        .wrReq   (wrReq),
        .exc     (exc),
        .strobes (strobes),
        .act     (act)
    );

    cp0Timer #(
        .countDivBits (countDivBits)
    ) timerInst (
        .clk     (clk),
        .reset   (reset),
        .strobes (strobes),
        .wrData  (wrReq.data),
        .count   (count),
        .compare (compare),
        .ti      (ti)
    );

    cp0ExcRegs #(
        .ebaseReset   (ebaseReset),
        .config0Reset (config0Reset)
    ) excRegsInst (
        .clk     (clk),
        .reset   (reset),
        .strobes (strobes),
        .act     (act),
        .wrData  (wrReq.data),
        .hwInt   (hwInt),
        .ti      (ti),
        .count   (count),
        .compare (compare),
        .state   (state),
        .view    (view)
    );

    cp0ReadMux #(
        .pridValue (pridValue)
    ) readMuxInst (
        .rdAddr  (rdAddr),
        .rdSel   (rdSel),
        .state   (state),
        .count   (count),
        .compare (compare),
        .rdData  (rdData)
    );

endmodule

`default_nettype wire

// File: hw/cp0WriteDecode.sv
// Move-to-CP0 strobe decode and exception classification
`default_nettype none

module cp0WriteDecode
    import cp0Pkg::*;
    import excPkg::*;
(
    input  cp0WriteReq wrReq,
    input  excEvent    exc,
    output regStrobes  strobes,
    output excAction   act
);

    logic selZero;
    logic selOne;

    assign selZero = (wrReq.sel == 3'd0);
    assign selOne  = (wrReq.sel == 3'd1);

    always_comb begin
        strobes         = '0;
        strobes.status  = wrReq.wrEn && (wrReq.addr == regStatus);
        strobes.cause   = wrReq.wrEn && (wrReq.addr == regCause);
        strobes.epc     = wrReq.wrEn && (wrReq.addr == regEpc);
        strobes.compare = wrReq.wrEn && (wrReq.addr == regCompare);
        strobes.count   = wrReq.wrEn && (wrReq.addr == regCount);
        strobes.ebase   = wrReq.wrEn && (wrReq.addr == regPrid) && selOne;
        strobes.config0 = wrReq.wrEn && (wrReq.addr == regConfig) && selZero;
    end

    always_comb begin
        act             = '0;
        act.take        = (exc.kind != excNone) && (exc.kind != excRefetch);
        act.isEret      = (exc.kind == excEret);
        act.inDelaySlot = exc.inDelaySlot;
        act.epcValue    = exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;
        act.setCe       = (exc.kind == excCpU);
        act.codeValid   = 1'b1;
        act.code        = codeInt;

        case (exc.kind)
            excInterrupt: act.code = codeInt;
            excAdelFetch: begin
                act.code     = codeAdEL;
                act.badValid = 1'b1;
                act.badAddr  = exc.pc;     // Fetch address faulted
            end
            excAdelData: begin
                act.code     = codeAdEL;
                act.badValid = 1'b1;
                act.badAddr  = exc.aluOut;
            end
            excAdesData: begin
                act.code     = codeAdES;
                act.badValid = 1'b1;
                act.badAddr  = exc.aluOut;
            end
            excSyscall:  act.code = codeSys;
            excBreak:    act.code = codeBp;
            excReserved: act.code = codeRI;
            excCpU:      act.code = codeCpU;
            excOverflow: act.code = codeOv;
            excTrap:     act.code = codeTr;
            default:     act.codeValid = 1'b0;  // None, ERET, refetch
        endcase
    end

endmodule

`default_nettype wire

// File: hw/excPkg.sv
// Exception kinds, architectural ExcCodes and the exception event/action structs
`default_nettype none

package excPkg;

    typedef enum logic [3:0] {
        excNone,
        excInterrupt,
        excAdelFetch,
        excAdelData,
        excAdesData,
        excSyscall,
        excBreak,
        excReserved,
        excCpU,
        excOverflow,
        excTrap,
        excEret,
        excRefetch      // Pipeline flush only, no CP0 update
    } excKind;

    typedef enum logic [4:0] {
        codeInt  = 5'd0,
        codeAdEL = 5'd4,
        codeAdES = 5'd5,
        codeSys  = 5'd8,
        codeBp   = 5'd9,
        codeRI   = 5'd10,
        codeCpU  = 5'd11,
        codeOv   = 5'd12,
        codeTr   = 5'd13
    } excCodeT;

    typedef struct packed {
        excKind      kind;
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic        inDelaySlot;
    } excEvent;

    typedef struct packed {
        logic        take;
        logic        isEret;
        logic        codeValid;
        excCodeT     code;
        logic [31:0] epcValue;
        logic        inDelaySlot;   // Loaded into Cause.BD
        logic        badValid;
        logic [31:0] badAddr;
        logic        setCe;
    } excAction;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the CP0 testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cp0Tb \
    -f cp0Regs.f \
    -o cp0Sim

./obj_dir/cp0Sim +verilator+error+limit+100 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failure"

// File: tests/cp0Tb.sv
// CP0 testbench with clock, reset, LFSR stimulus, reference model, checks and report
`default_nettype none

module cp0Tb
    import cp0Pkg::*;
    import excPkg::*;
();

    localparam logic [31:0] pridValue    = 32'h00004220;
    localparam logic [31:0] ebaseReset   = 32'h80000000;
    localparam logic [31:0] config0Reset = 32'h80000483;
    localparam int countDivBits = 1;
    localparam int countPeriod  = 1 << countDivBits;
    localparam int drvDelay     = 2;
    localparam int maxCycles    = 1200;    // About five times the full run

    logic clk;
    logic reset;
    logic [5:0] hwInt;
    cp0WriteReq wrReq;
    excEvent exc;
    cp0RegAddr rdAddr;
    logic [2:0] rdSel;
    logic [31:0] rdData;
    cp0View view;

    // Reference model state
    logic mBev;
    logic [7:0] mIm;
    logic mExl;
    logic mIe;
    logic mBd;
    logic mTi;
    logic [1:0] mCe;
    logic [7:0] mIp;
    logic [4:0] mCode;
    logic [31:0] mEpc;
    logic [31:0] mBad;
    logic [31:0] mEbase;
    logic [31:0] mCount;
    logic [31:0] mCompare;
    logic [2:0] mK0;
    int mPhase;

    logic excTakes;
    logic excFirst;
    logic [5:0] codeInfo;

    logic [31:0] lfsr = 32'h9cd9b625;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    cp0Top #(
        .pridValue    (pridValue),
        .ebaseReset   (ebaseReset),
        .config0Reset (config0Reset),
        .countDivBits (countDivBits)
    ) cp0Top_inst (
        .clk    (clk),
        .reset  (reset),
        .hwInt  (hwInt),
        .wrReq  (wrReq),
        .exc    (exc),
        .rdAddr (rdAddr),
        .rdSel  (rdSel),
        .rdData (rdData),
        .view   (view)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic fb;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            v = {v[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
        return v;
    endfunction

    // Valid flag in bit 5 above the architectural code
    function automatic logic [5:0] expectCode(input excKind k);
        case (k)
            excInterrupt:              return {1'b1, 5'd0};
            excAdelFetch, excAdelData: return {1'b1, 5'd4};
            excAdesData:               return {1'b1, 5'd5};
            excSyscall:                return {1'b1, 5'd8};
            excBreak:                  return {1'b1, 5'd9};
            excReserved:               return {1'b1, 5'd10};
            excCpU:                    return {1'b1, 5'd11};
            excOverflow:               return {1'b1, 5'd12};
            excTrap:                   return {1'b1, 5'd13};
            default:                   return 6'd0;
        endcase
    endfunction

    function automatic logic wrOn(input cp0RegAddr a, input logic [2:0] s, input logic anySel);
        return wrReq.wrEn && (wrReq.addr == a) && (anySel || wrReq.sel == s);
    endfunction

    function automatic logic [31:0] expectRead(input cp0RegAddr a, input logic [2:0] s);
        case (a)
            regBadVAddr: return mBad;
            regCount:    return mCount;
            regCompare:  return mCompare;
            regStatus:   return {9'd0, mBev, 6'd0, mIm, 6'd0, mExl, mIe};
            regCause:    return {mBd, mTi, mCe, 12'd0, mIp, 1'b0, mCode, 2'd0};
            regEpc:      return mEpc;
            regPrid:     return (s == 3'd0) ? pridValue : (s == 3'd1) ? mEbase : 32'd0;
            regConfig:   return (s == 3'd0) ? {config0Reset[31:3], mK0} : 32'd0;
            default:     return 32'd0;
        endcase
    endfunction

    assign excTakes = (exc.kind != excNone) && (exc.kind != excRefetch);
    assign excFirst = excTakes && (exc.kind != excEret) && !mExl;
    assign codeInfo = expectCode(exc.kind);

    always @(posedge clk) begin
        if (reset) begin
            mBev     <= 1'b1;
            mIm      <= '0;
            mExl     <= 1'b0;
            mIe      <= 1'b0;
            mBd      <= 1'b0;
            mTi      <= 1'b0;
            mCe      <= '0;
            mIp      <= '0;
            mCode    <= '0;
            mEpc     <= '0;
            mBad     <= '0;
            mEbase   <= ebaseReset;
            mK0      <= config0Reset[2:0];
            mCount   <= '0;
            mCompare <= '0;
            mPhase   <= 0;
        end else begin
            if (wrOn(regStatus, 3'd0, 1'b1)) begin
                mBev <= wrReq.data[22];
                mIm  <= wrReq.data[15:8];
                mExl <= wrReq.data[1];
                mIe  <= wrReq.data[0];
            end
            if (excTakes) mExl <= (exc.kind != excEret);   // Wins over the move
            if (excFirst) begin
                mEpc <= exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;
                mBd  <= exc.inDelaySlot;
            end else if (!excTakes && wrOn(regEpc, 3'd0, 1'b1)) begin
                mEpc <= wrReq.data;
            end
            if (codeInfo[5]) mCode <= codeInfo[4:0];
            if (exc.kind == excCpU) mCe <= 2'd1;
            if (exc.kind == excAdelFetch) mBad <= exc.pc;
            if (exc.kind == excAdelData || exc.kind == excAdesData) mBad <= exc.aluOut;
            mIp[7:2] <= {hwInt[5] | mTi, hwInt[4:0]};
            if (wrOn(regCause, 3'd0, 1'b1)) mIp[1:0] <= wrReq.data[9:8];
            if (wrOn(regPrid, 3'd1, 1'b0)) begin
                mEbase <= {ebaseReset[31:30], wrReq.data[29:12], ebaseReset[11:0]};
            end
            if (wrOn(regConfig, 3'd0, 1'b0)) mK0 <= wrReq.data[2:0];
            if (wrOn(regCount, 3'd0, 1'b1)) begin
                mCount <= wrReq.data;
                mPhase <= 0;
            end else if (mPhase + 1 == countPeriod) begin
                mCount <= mCount + 32'd1;
                mPhase <= 0;
            end else begin
                mPhase <= mPhase + 1;
            end
            if (wrOn(regCompare, 3'd0, 1'b1)) begin
                mCompare <= wrReq.data;
                mTi      <= 1'b0;
            end else if (mCount == mCompare) begin
                mTi <= 1'b1;
            end
        end
    end

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            checkEq("rdData", rdData, expectRead(rdAddr, rdSel));
            checkEq("view.bev", 32'(view.bev), 32'(mBev));
            checkEq("view.im", 32'(view.im), 32'(mIm));
            checkEq("view.exl", 32'(view.exl), 32'(mExl));
            checkEq("view.ie", 32'(view.ie), 32'(mIe));
            checkEq("view.ip", 32'(view.ip), 32'(mIp));
            checkEq("view.epc", view.epc, mEpc);
            checkEq("view.ebase", view.ebase, mEbase);
            checkEq("view.k0", 32'(view.k0), 32'(mK0));
            checkEq("view.irqPending", 32'(view.irqPending), 32'(mIe && !mExl && |(mIp & mIm)));
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: run did not finish within %0d cycles", maxCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #drvDelay;
        wrReq.wrEn = 1'b0;
        exc.kind   = excNone;
    endtask

    task automatic moveTo(input cp0RegAddr a, input logic [2:0] s, input logic [31:0] d);
        nextCycle();
        wrReq.wrEn = 1'b1;
        wrReq.addr = a;
        wrReq.sel  = s;
        wrReq.data = d;
        rdAddr     = a;
        rdSel      = s;
    endtask

    task automatic readReg(input cp0RegAddr a, input logic [2:0] s);
        nextCycle();
        rdAddr = a;
        rdSel  = s;
    endtask

    task automatic raise(input excKind k, input logic [31:0] pc, input logic [31:0] alu,
                         input logic ds);
        nextCycle();
        exc.kind        = k;
        exc.pc          = pc;
        exc.aluOut      = alu;
        exc.inDelaySlot = ds;
    endtask

    task automatic resetValues();
        readReg(regStatus, 3'd0);
        readReg(regCause, 3'd0);
        readReg(regEpc, 3'd0);
        readReg(regBadVAddr, 3'd0);
        readReg(regCount, 3'd0);
        readReg(regCompare, 3'd0);
        readReg(regPrid, 3'd0);
        readReg(regPrid, 3'd1);
        readReg(regConfig, 3'd0);
        readReg(cp0RegAddr'(5'd0), 3'd0);  // Unimplemented
        readReg(cp0RegAddr'(5'd31), 3'd0);
        readReg(regConfig, 3'd1);
        readReg(regPrid, 3'd2);
    endtask

    task automatic writeReadBack();
        int i;
        for (i = 0; i < 4; i++) begin
            moveTo(regStatus, 3'd0, randBits(32));
            readReg(regStatus, 3'd0);
            moveTo(regCause, 3'd0, randBits(32));
            readReg(regCause, 3'd0);
            moveTo(regEpc, 3'd0, randBits(32));
            readReg(regEpc, 3'd0);
            moveTo(regPrid, 3'd1, randBits(32));
            readReg(regPrid, 3'd1);
            moveTo(regConfig, 3'd0, randBits(32));
            readReg(regConfig, 3'd0);
        end
        moveTo(regPrid, 3'd0, randBits(32));     // PRId is read-only
        readReg(regPrid, 3'd0);
        moveTo(regConfig, 3'd2, randBits(32));
        readReg(regConfig, 3'd0);
    endtask

    task automatic exceptionCapture();
        excKind k;
        moveTo(regStatus, 3'd0, 32'h0040_0000);
        for (k = excInterrupt; k != excEret; k = k.next()) begin
            raise(k, {30'(randBits(30)), 2'b00}, randBits(32), 1'(randBits(1)));
            readReg(regEpc, 3'd0);
            readReg(regBadVAddr, 3'd0);
            readReg(regCause, 3'd0);
            readReg(regStatus, 3'd0);
            raise(excEret, 32'd0, 32'd0, 1'b0);
        end
    endtask

    task automatic nestedAndEret();
        raise(excSyscall, 32'h0000_1000, 32'd0, 1'b0);
        readReg(regEpc, 3'd0);
        raise(excOverflow, 32'h0000_2000, 32'd0, 1'b1);    // Nested
        readReg(regEpc, 3'd0);
        readReg(regCause, 3'd0);
        nextCycle();                                       // EPC move loses
        wrReq = '{wrEn: 1'b1, addr: regEpc, sel: 3'd0, data: 32'h1234_5678};
        exc.kind = excTrap;
        readReg(regEpc, 3'd0);
        raise(excRefetch, 32'h0000_3000, 32'h0000_3333, 1'b1);
        readReg(regStatus, 3'd0);
        raise(excEret, 32'd0, 32'd0, 1'b0);
        readReg(regStatus, 3'd0);
        readReg(regEpc, 3'd0);
        nextCycle();                                       // Status move loses EXL
        wrReq = '{wrEn: 1'b1, addr: regStatus, sel: 3'd0, data: 32'h0040_0001};
        exc.kind = excBreak;
        exc.pc   = 32'h0000_4000;
        readReg(regStatus, 3'd0);
        raise(excEret, 32'd0, 32'd0, 1'b0);
        readReg(regStatus, 3'd0);
    endtask

    task automatic timerRun();
        int i;
        moveTo(regCount, 3'd0, 32'h0000_0100);
        moveTo(regCompare, 3'd0, 32'h0000_010A);
        for (i = 0; i < 26; i++) begin
            readReg(regCount, 3'd0);
        end
        readReg(regCause, 3'd0);
        moveTo(regCompare, 3'd0, 32'h0000_0200);  // Clears TI
        readReg(regCause, 3'd0);
        readReg(regCause, 3'd0);
        moveTo(regCount, 3'd0, randBits(32));
        for (i = 0; i < 6; i++) begin
            readReg(regCount, 3'd0);
        end
    endtask

    task automatic interruptSummary();
        int i;
        for (i = 0; i < 48; i++) begin
            nextCycle();
            hwInt  = 6'(randBits(6));
            rdAddr = regCause;
            rdSel  = 3'd0;
            if (i % 4 == 0) begin
                wrReq = '{wrEn: 1'b1, addr: regStatus, sel: 3'd0, data: randBits(32)};
            end else if (i % 8 == 2) begin
                wrReq = '{wrEn: 1'b1, addr: regCause, sel: 3'd0, data: randBits(32)};
            end
        end
    endtask

    initial begin
        reset  = 1'b1;
        hwInt  = '0;
        wrReq  = '0;
        exc    = '0;
        rdAddr = regStatus;
        rdSel  = 3'd0;
        repeat (3) @(posedge clk);
        #drvDelay;
        reset = 1'b0;

        resetValues();
        writeReadBack();
        exceptionCapture();
        nestedAndEret();
        timerRun();
        interruptSummary();
        readReg(regStatus, 3'd0);
        readReg(regCause, 3'd0);
        nextCycle();

        $display("Checks: %0d, errors: %0d, bound assertion failures: %0d",
                 checkCount, errorCount, cp0Top_inst.chkInst.failCount);
        if (errorCount == 0 && cp0Top_inst.chkInst.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/cp0Top_chk.sv
// Concurrent reset, exception and EPC assertions bound into cp0Top
`default_nettype none

module cp0TopChk
    import cp0Pkg::*;
    import excPkg::*;
(
    input logic     clk,
    input logic     reset,
    input excAction act,
    input cp0State  state
);

    int unsigned failCount = 0;    // Read by the testbench at the end

    bevAfterReset: assert property (@(posedge clk) reset |=> state.bev)
        else begin
            $error("BEV is clear in the cycle after reset");
            failCount++;
        end

    // Taken exception, not ERET
    exlRises: assert property (@(posedge clk) disable iff (reset)
        act.take && !act.isEret |=> state.exl)
        else begin
            $error("EXL did not rise after a taken exception");
            failCount++;
        end

    epcHeldWhenNested: assert property (@(posedge clk) disable iff (reset)
        act.take && !act.isEret && state.exl |=> $stable(state.epc))
        else begin
            $error("EPC changed on an exception taken with EXL set");
            failCount++;
        end

endmodule

bind cp0Top cp0TopChk chkInst (
    .clk   (clk),
    .reset (reset),
    .act   (act),
    .state (state)
);

`default_nettype wire
